// File: logic/lv_pkg.sv
/* LV die shared definitions */
package lv_pkg;

    // ==========================================================
    // widths
    // ==========================================================
    localparam int REG_AW      = 7;
    localparam int REG_DW      = 8;
    localparam int SPI_FRAME_W = 16;    // op, addr, data
    localparam int SPI_CNT_W   = 5;     // room to count past a full frame
    localparam int VGE_DLY_W   = 4;
    localparam int MM_CNT_W    = VGE_DLY_W + 1;
    localparam int IO_STATUS_W = 6;
    localparam int ST_ERR_W    = 3;

    // STATUS1 bit positions
    localparam int ST_SPI_ERR  = 0;
    localparam int ST_DT_ERR   = 1;
    localparam int ST_MM_ERR   = 2;

    localparam logic [REG_DW-1:0] CONFIG0_RST = 8'h08;

    // ==========================================================
    // enums
    // ==========================================================
    typedef enum logic {
        SPI_OP_RD = 1'b0,
        SPI_OP_WR = 1'b1
    } spi_op_e;

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_DONE
    } spi_st_e;

    typedef enum logic [REG_AW-1:0] {
        ADDR_STATUS1   = 7'h00,   // sticky errors, w1c
        ADDR_CONFIG0   = 7'h01,
        ADDR_BGR_TRIM  = 7'h02,
        ADDR_IO_STATUS = 7'h03    // read only
    } reg_addr_e;

endpackage

// File: logic/lv_spi_if.sv
/* SPI frame link */
`timescale 1ns/1ps

interface lv_spi_if import lv_pkg::*; ();

    logic                   frame_vld;    // full 16 bit frame
    logic                   frame_err;    // any other bit count
    logic [SPI_FRAME_W-1:0] frame_data;
    logic [SPI_FRAME_W-1:0] rsp_word;     // goes out in the next frame

    modport spi (
        output frame_vld,
        output frame_err,
        output frame_data,
        input  rsp_word
    );

    modport rac (
        input  frame_vld,
        input  frame_err,
        input  frame_data,
        output rsp_word
    );

endinterface

// File: logic/lv_reg_if.sv
/* register request link */
`timescale 1ns/1ps

interface lv_reg_if import lv_pkg::*; ();

    logic              req;     // one cycle strobe
    logic              wr;
    logic [REG_AW-1:0] addr;
    logic [REG_DW-1:0] wdata;
    logic              ack;     // req + 1
    logic [REG_DW-1:0] rdata;   // value after write on wr

    modport rac (
        output req,
        output wr,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport slv (
        input  req,
        input  wr,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

// File: logic/lv_spi_slv.sv
/* SPI slave framer */
`timescale 1ns/1ps

module lv_spi_slv import lv_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    input  logic  i_spi_sclk,
    input  logic  i_spi_csb,
    input  logic  i_spi_mosi,
    output logic  o_spi_miso,
    lv_spi_if.spi o_spi
);

    logic [2:0]             pin_meta;     // {sclk, csb, mosi}
    logic [2:0]             pin_sync;
    logic                   sclk_d;
    logic                   csb_d;
    logic                   sclk_rise;
    logic                   sclk_fall;
    logic                   csb_rise;
    logic                   csb_fall;
    spi_st_e                state;
    logic [SPI_CNT_W-1:0]   bit_cnt;
    logic [SPI_FRAME_W-1:0] rx_sreg;
    logic [SPI_FRAME_W-1:0] tx_sreg;
    logic                   cnt_full;

    // ==========================================================
    // pin sync and edge detect
    // ==========================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pin_meta <= 3'b010;     // csb idles high
            pin_sync <= 3'b010;
            sclk_d   <= 1'b0;
            csb_d    <= 1'b1;
        end else begin
            pin_meta <= {i_spi_sclk, i_spi_csb, i_spi_mosi};
            pin_sync <= pin_meta;
            sclk_d   <= pin_sync[2];
            csb_d    <= pin_sync[1];
        end
    end

    assign sclk_rise = pin_sync[2] & ~sclk_d;
    assign sclk_fall = ~pin_sync[2] & sclk_d;
    assign csb_rise  = pin_sync[1] & ~csb_d;
    assign csb_fall  = ~pin_sync[1] & csb_d;

    // ==========================================================
    // frame FSM
    // ==========================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= SPI_IDLE;
            bit_cnt <= '0;
        end else begin
            unique case (state)
                SPI_IDLE: begin
                    if (csb_fall) begin
                        state   <= SPI_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                SPI_SHIFT: begin
                    if (csb_rise) begin
                        state <= SPI_DONE;
                    end else if (sclk_rise && (bit_cnt != '1)) begin
                        bit_cnt <= bit_cnt + 1'b1;      // saturates on long frames
                    end
                end
                SPI_DONE: state <= SPI_IDLE;
                default:  state <= SPI_IDLE;
            endcase
        end
    end

    // mosi sampled on sclk rise
    always_ff @(posedge i_clk) begin
        if ((state == SPI_SHIFT) && sclk_rise) begin
            rx_sreg <= {rx_sreg[SPI_FRAME_W-2:0], pin_sync[0]};
        end
    end

    // reply loaded at csb fall, shifted on sclk fall
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_sreg <= '0;
        end else if ((state == SPI_IDLE) && csb_fall) begin
            tx_sreg <= o_spi.rsp_word;
        end else if ((state == SPI_SHIFT) && sclk_fall) begin
            tx_sreg <= {tx_sreg[SPI_FRAME_W-2:0], 1'b0};
        end
    end

    assign o_spi_miso = tx_sreg[SPI_FRAME_W-1];

    assign cnt_full         = (bit_cnt == SPI_CNT_W'(SPI_FRAME_W));
    assign o_spi.frame_vld  = (state == SPI_DONE) && cnt_full;
    assign o_spi.frame_err  = (state == SPI_DONE) && !cnt_full;
    assign o_spi.frame_data = rx_sreg;

endmodule

// File: logic/lv_reg_access_ctrl.sv
/* register access controller */
`timescale 1ns/1ps

module lv_reg_access_ctrl import lv_pkg::*; (
    input  logic  i_clk,
    input  logic  i_rst_n,
    lv_spi_if.rac i_spi,
    lv_reg_if.rac o_reg,
    output logic  o_spi_err
);

    spi_op_e frame_op;
    logic    ack_pend;      // req issued, ack not yet seen

    assign frame_op = spi_op_e'(i_spi.frame_data[SPI_FRAME_W-1]);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_reg.req      <= 1'b0;
            o_spi_err      <= 1'b0;
            ack_pend       <= 1'b0;
            i_spi.rsp_word <= '0;
        end else begin
            o_reg.req <= i_spi.frame_vld;
            o_spi_err <= i_spi.frame_err;       // error frames never reach the bank
            if (o_reg.req) begin
                ack_pend <= 1'b1;
            end else if (o_reg.ack) begin
                ack_pend <= 1'b0;
            end
            if (o_reg.ack && ack_pend) begin
                i_spi.rsp_word <= {1'b0, o_reg.addr, o_reg.rdata};
            end
        end
    end

    // frame split, addr held until the next frame
    always_ff @(posedge i_clk) begin
        if (i_spi.frame_vld) begin
            o_reg.wr    <= (frame_op == SPI_OP_WR);
            o_reg.addr  <= i_spi.frame_data[REG_DW +: REG_AW];
            o_reg.wdata <= i_spi.frame_data[REG_DW-1:0];
        end
    end

    a_one_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_reg.req |-> !ack_pend);

    // bank answers exactly one cycle after the request
    a_ack_next_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_reg.ack == $past(o_reg.req));

    a_vld_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_spi.frame_vld && i_spi.frame_err));

endmodule

// File: logic/lv_reg_slv.sv
/* LV register bank */
`timescale 1ns/1ps

module lv_reg_slv import lv_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    lv_reg_if.slv                  i_reg,
    input  logic                   i_spi_err,
    input  logic                   i_pwm_dterr,
    input  logic                   i_pwm_mmerr,
    input  logic [IO_STATUS_W-1:0] i_io_status,
    output logic [VGE_DLY_W-1:0]   o_vge_mon_dly,
    output logic [REG_DW-1:0]      o_reg_iso_bgr_trim
);

    logic                status_wr;
    logic                config0_wr;
    logic                trim_wr;
    logic [ST_ERR_W-1:0] status1;
    logic [ST_ERR_W-1:0] status1_set;
    logic [ST_ERR_W-1:0] status1_clr;
    logic [ST_ERR_W-1:0] status1_nxt;
    logic [REG_DW-1:0]   config0;
    logic [REG_DW-1:0]   config0_nxt;
    logic [REG_DW-1:0]   trim_nxt;
    logic [REG_DW-1:0]   rd_mux;

    // read-only and unmapped writes fall through here
    assign status_wr  = i_reg.req && i_reg.wr && (i_reg.addr == ADDR_STATUS1);
    assign config0_wr = i_reg.req && i_reg.wr && (i_reg.addr == ADDR_CONFIG0);
    assign trim_wr    = i_reg.req && i_reg.wr && (i_reg.addr == ADDR_BGR_TRIM);

    always_comb begin
        status1_set             = '0;
        status1_set[ST_SPI_ERR] = i_spi_err;
        status1_set[ST_DT_ERR]  = i_pwm_dterr;
        status1_set[ST_MM_ERR]  = i_pwm_mmerr;
    end

    assign status1_clr = status_wr ? i_reg.wdata[ST_ERR_W-1:0] : '0;
    assign status1_nxt = (status1 & ~status1_clr) | status1_set;     // set beats clear
    assign config0_nxt = config0_wr ? i_reg.wdata : config0;
    assign trim_nxt    = trim_wr ? i_reg.wdata : o_reg_iso_bgr_trim;

    // ==========================================================
    // storage
    // ==========================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            status1            <= '0;
            config0            <= CONFIG0_RST;
            o_reg_iso_bgr_trim <= '0;
            i_reg.ack          <= 1'b0;
        end else begin
            status1            <= status1_nxt;
            config0            <= config0_nxt;
            o_reg_iso_bgr_trim <= trim_nxt;
            i_reg.ack          <= i_reg.req;
        end
    end

    // read data reflects the post-write value
    always_comb begin
        case (i_reg.addr)
            ADDR_STATUS1:   rd_mux = REG_DW'(status1_nxt);
            ADDR_CONFIG0:   rd_mux = config0_nxt;
            ADDR_BGR_TRIM:  rd_mux = trim_nxt;
            ADDR_IO_STATUS: rd_mux = REG_DW'(i_io_status);   // live pins
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reg.req) begin
            i_reg.rdata <= rd_mux;
        end
    end

    assign o_vge_mon_dly = config0[VGE_DLY_W-1:0];

endmodule

// File: logic/lv_pwm_mon.sv
/* PWM feedback monitor */
`timescale 1ns/1ps

module lv_pwm_mon import lv_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_lv_pwm_dt,
    input  logic                 i_lv_gate_vs_pwm,
    input  logic [VGE_DLY_W-1:0] i_vge_mon_dly,
    output logic                 o_pwm_dterr,
    output logic                 o_pwm_mmerr
);

    logic [1:0]          pin_meta;    // {dt, mm}
    logic [1:0]          pin_sync;
    logic [1:0]          dt_hist;     // last two dt samples
    logic [MM_CNT_W-1:0] mm_cnt;
    logic [MM_CNT_W-1:0] mm_thr;

    assign mm_thr = {1'b0, i_vge_mon_dly} + MM_CNT_W'(2);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pin_meta    <= '0;
            pin_sync    <= '0;
            dt_hist     <= '0;
            mm_cnt      <= '0;
            o_pwm_dterr <= 1'b0;
            o_pwm_mmerr <= 1'b0;
        end else begin
            pin_meta <= {i_lv_pwm_dt, i_lv_gate_vs_pwm};
            pin_sync <= pin_meta;
            dt_hist  <= {dt_hist[0], pin_sync[1]};

            // second high sample in a row, once per stretch
            o_pwm_dterr <= pin_sync[1] && dt_hist[0] && !dt_hist[1];

            if (!pin_sync[0]) begin
                mm_cnt <= '0;                   // restart on fall
            end else if (mm_cnt != '1) begin
                mm_cnt <= mm_cnt + 1'b1;
            end
            o_pwm_mmerr <= pin_sync[0] && (mm_cnt == mm_thr);
        end
    end

endmodule

// File: logic/lv_core.sv
/* LV die register core */
`timescale 1ns/1ps

module lv_core import lv_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_spi_sclk,
    input  logic                 i_spi_csb,
    input  logic                 i_spi_mosi,
    output logic                 o_spi_miso,
    input  logic                 i_lv_pwm_dt,
    input  logic                 i_lv_gate_vs_pwm,
    input  logic                 i_io_pwma,
    input  logic                 i_io_pwm,
    input  logic                 i_io_fsstate,
    input  logic                 i_io_fsenb_n,
    input  logic                 i_io_intb,
    input  logic                 i_io_inta,
    output logic [REG_DW-1:0]    o_reg_iso_bgr_trim,
    output logic [VGE_DLY_W-1:0] o_reg_config0_vge_mon_dly
);

    logic spi_err;
    logic pwm_dterr;
    logic pwm_mmerr;

    lv_spi_if spi_bus ();
    lv_reg_if reg_bus ();

    // ==========================================================
    // spi -> access ctrl -> register bank
    // ==========================================================
    lv_spi_slv u_spi_slv (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_spi_sclk (i_spi_sclk),
        .i_spi_csb  (i_spi_csb),
        .i_spi_mosi (i_spi_mosi),
        .o_spi_miso (o_spi_miso),
        .o_spi      (spi_bus.spi)
    );

    lv_reg_access_ctrl u_reg_access_ctrl (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_spi     (spi_bus.rac),
        .o_reg     (reg_bus.rac),
        .o_spi_err (spi_err)
    );

    lv_reg_slv u_reg_slv (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_reg              (reg_bus.slv),
        .i_spi_err          (spi_err),
        .i_pwm_dterr        (pwm_dterr),
        .i_pwm_mmerr        (pwm_mmerr),
        .i_io_status        ({i_io_pwma, i_io_pwm, i_io_fsstate,
                              i_io_fsenb_n, i_io_intb, i_io_inta}),
        .o_vge_mon_dly      (o_reg_config0_vge_mon_dly),
        .o_reg_iso_bgr_trim (o_reg_iso_bgr_trim)
    );

    lv_pwm_mon u_pwm_mon (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_lv_pwm_dt      (i_lv_pwm_dt),
        .i_lv_gate_vs_pwm (i_lv_gate_vs_pwm),
        .i_vge_mon_dly    (o_reg_config0_vge_mon_dly),   // from CONFIG0
        .o_pwm_dterr      (pwm_dterr),
        .o_pwm_mmerr      (pwm_mmerr)
    );

endmodule

// File: dv/lv_core_tb.sv
/* LV core testbench */
`timescale 1ns/1ps

module lv_core_tb;

    localparam int SCLK_HALF = 8;     // clocks per sclk half period
    localparam int FRAME_GAP = 12;    // clocks between frames
    localparam int VEC_CYCLES = 500;

    logic       i_clk = 1'b0;
    logic       i_rst_n;
    logic       i_spi_sclk;
    logic       i_spi_csb;
    logic       i_spi_mosi;
    logic       o_spi_miso;
    logic       i_lv_pwm_dt;
    logic       i_lv_gate_vs_pwm;
    logic       i_io_pwma;
    logic       i_io_pwm;
    logic       i_io_fsstate;
    logic       i_io_fsenb_n;
    logic       i_io_intb;
    logic       i_io_inta;
    logic [7:0] o_reg_iso_bgr_trim;
    logic [3:0] o_reg_config0_vge_mon_dly;

    logic [15:0] exp_rsp;     // reply owed by the previous frame
    logic [7:0]  trim_exp;
    logic [3:0]  dly_exp;
    logic [15:0] lfsr;
    logic [7:0]  rnd_last;
    string       vecs[$];
    int          errors;
    int          checks;
    int          cycles;
    int          limit;

    lv_core dut_i (.*);

    always #5 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if ((limit != 0) && (cycles >= limit)) begin
            $display("run stopped: no progress after %0d clock cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // ==========================================================
    // helpers
    // ==========================================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // taps 16 14 13 11
    endfunction

    task automatic draw_rand_byte();
        int b;
        for (b = 0; b < 8; b++) begin
            lfsr     = lfsr_step(lfsr);
            rnd_last = {rnd_last[6:0], lfsr[0]};
        end
    endtask

    function automatic int field_val(input string s);
        if (s == "RR") begin
            return {24'h0, rnd_last};
        end
        return s.atohex();
    endfunction

    // mode 0, msb first; miso sampled just before each sclk rise
    task automatic spi_xfer(input logic [15:0] mosi_word, input int nbits,
                            output logic [15:0] miso_word);
        logic [15:0] tx;
        int          i;
        tx        = mosi_word;
        miso_word = '0;
        @(negedge i_clk);
        i_spi_csb  = 1'b0;
        i_spi_mosi = tx[15];
        repeat (SCLK_HALF) @(negedge i_clk);
        for (i = 0; i < nbits; i++) begin
            miso_word  = {miso_word[14:0], o_spi_miso};
            i_spi_sclk = 1'b1;
            repeat (SCLK_HALF) @(negedge i_clk);
            i_spi_sclk = 1'b0;
            tx         = tx << 1;
            i_spi_mosi = tx[15];
            repeat (SCLK_HALF) @(negedge i_clk);
        end
        i_spi_csb  = 1'b1;
        i_spi_mosi = 1'b0;
        repeat (FRAME_GAP) @(negedge i_clk);
    endtask

    task automatic frame_check(input logic [15:0] word, input int nbits);
        logic [15:0] got;
        logic [15:0] want;
        spi_xfer(word, nbits, got);
        want = exp_rsp >> (16 - nbits);     // short frames see only the top bits
        checks++;
        if (got !== want) begin
            $display("FAIL o_spi_miso reply: expected 0x%04h, got 0x%04h", want, got);
            errors++;
        end
    endtask

    task automatic check_ports();
        checks++;
        if (o_reg_iso_bgr_trim !== trim_exp) begin
            $display("FAIL o_reg_iso_bgr_trim: expected 0x%02h, got 0x%02h",
                     trim_exp, o_reg_iso_bgr_trim);
            errors++;
        end
        checks++;
        if (o_reg_config0_vge_mon_dly !== dly_exp) begin
            $display("FAIL o_reg_config0_vge_mon_dly: expected 0x%01h, got 0x%01h",
                     dly_exp, o_reg_config0_vge_mon_dly);
            errors++;
        end
    endtask

    task automatic run_vector(input string op, input string f1, input string f2,
                              input string f3);
        int a;
        int d;
        int r;
        a = field_val(f1);
        if ((op == "W") && (f2 == "RR")) begin
            draw_rand_byte();
        end
        d = field_val(f2);
        r = field_val(f3);
        case (op)
            "W": begin
                frame_check({1'b1, a[6:0], d[7:0]}, 16);
                exp_rsp = {1'b0, a[6:0], r[7:0]};     // value after the write
                if (a == 1) dly_exp = r[3:0];
                if (a == 2) trim_exp = r[7:0];
            end
            "R": begin
                frame_check({1'b0, a[6:0], 8'h00}, 16);
                exp_rsp = {1'b0, a[6:0], d[7:0]};
            end
            "S": frame_check(16'h0000, a);            // reply stays owed
            "P": begin
                @(negedge i_clk);
                if (a == 0) i_lv_gate_vs_pwm = 1'b1;
                else i_lv_pwm_dt = 1'b1;
                repeat (d) @(negedge i_clk);
                i_lv_gate_vs_pwm = 1'b0;
                i_lv_pwm_dt      = 1'b0;
                repeat (20) @(negedge i_clk);
            end
            "I": begin
                @(negedge i_clk);
                {i_io_pwma, i_io_pwm, i_io_fsstate,
                 i_io_fsenb_n, i_io_intb, i_io_inta} = a[5:0];
            end
            default: begin
                $display("unknown vector operation %s", op);
                errors++;
            end
        endcase
        check_ports();
    endtask

    // ==========================================================
    // main sequence
    // ==========================================================
    initial begin
        int    fd;
        int    k;
        string line;
        string op, f1, f2, f3;
        i_rst_n = 1'b0;
        i_spi_sclk = 1'b0;
        i_spi_csb = 1'b1;
        i_spi_mosi = 1'b0;
        i_lv_pwm_dt = 1'b0;
        i_lv_gate_vs_pwm = 1'b0;
        {i_io_pwma, i_io_pwm, i_io_fsstate, i_io_fsenb_n, i_io_intb, i_io_inta} = '0;
        exp_rsp  = '0;
        trim_exp = '0;
        dly_exp  = 4'h8;
        lfsr     = 16'd55;
        rnd_last = '0;
        errors   = 0;
        checks   = 0;
        limit    = 0;

        fd = $fopen("dv/lv_core_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file dv/lv_core_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    if ((line.len() > 1) && (line.substr(0, 0) != "#")) vecs.push_back(line);
                end
            end
            $fclose(fd);
        end
        limit = vecs.size() * VEC_CYCLES + 200;

        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;
        repeat (4) @(negedge i_clk);
        check_ports();

        for (k = 0; k < vecs.size(); k++) begin
            if ($sscanf(vecs[k], "%s %s %s %s", op, f1, f2, f3) != 4) begin
                $display("vector %0d could not be parsed", k + 1);
                errors++;
            end else begin
                run_vector(op, f1, f2, f3);
            end
        end
        frame_check(16'h0000, 16);      // collect the last reply

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dv/lv_core_vectors.txt
# op f1 f2 f3: W addr data reply | R addr data - | S bits - - | P in(0 mm,1 dt) clocks - | I pins - -
# RR stands for the last random byte
R 02 00 0
R 01 08 0
W 02 5A 5A
R 02 5A 0
W 01 04 04
R 01 04 0
W 02 RR RR
R 02 RR 0
I 2D 0 0
W 03 FF 2D
R 03 2D 0
R 55 00 0
W 55 77 00
R 02 RR 0
R 01 04 0
S 0A 0 0
R 00 01 0
W 00 01 00
R 00 00 0
P 0 03 0
R 00 00 0
P 0 14 0
R 00 04 0
P 1 0A 0
R 00 06 0
W 00 02 04
W 00 04 00
R 00 00 0

// File: compile.f
logic/lv_pkg.sv
logic/lv_spi_if.sv
logic/lv_reg_if.sv
logic/lv_spi_slv.sv
logic/lv_reg_access_ctrl.sv
logic/lv_reg_slv.sv
logic/lv_pwm_mon.sv
logic/lv_core.sv
dv/lv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lv_core_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
